/* addr_gen.sv */
`default_nettype none

module addr_gen
   import yolo_write_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      start_pulse,
   input  gen_cfg_t  cfg,
   output mem_addr_t addr,
   output logic      en,
   output logic      done
);

   logic                busy;
   logic [period_w-1:0] delay_cnt;
   logic [period_w-1:0] per_cnt;
   mem_addr_t           iter_cnt;
   mem_addr_t           addr_q;
   logic                active;
   logic                per_last;
   logic                iter_last;

   // emitting once the initial delay has run out
   assign active    = busy & (delay_cnt == '0);
   assign per_last  = (per_cnt == cfg.per - 1'b1);
   assign iter_last = (iter_cnt == cfg.iter - 1'b1);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy      <= 1'b0;
         delay_cnt <= '0;
         per_cnt   <= '0;
         iter_cnt  <= '0;
         addr_q    <= '0;
      end else if (start_pulse) begin
         // empty loop never leaves idle
         busy      <= (cfg.iter != '0) && (cfg.per != '0);
         delay_cnt <= cfg.delay;
         per_cnt   <= '0;
         iter_cnt  <= '0;
         addr_q    <= cfg.start;
      end else if (busy) begin
         if (delay_cnt != '0) begin
            delay_cnt <= delay_cnt - 1'b1;
         end else if (per_last) begin
            per_cnt <= '0;
            addr_q  <= addr_q + cfg.shift;
            if (iter_last) begin
               busy     <= 1'b0;
               iter_cnt <= '0;
            end else begin
               iter_cnt <= iter_cnt + 1'b1;
            end
         end else begin
            per_cnt <= per_cnt + 1'b1;
            addr_q  <= addr_q + cfg.incr;
         end
      end
   end

   assign addr = addr_q;
   // first duty beats of every period
   assign en   = active & (per_cnt < cfg.duty);
   assign done = ~busy;

endmodule

`default_nettype wire

/* cfg_regs.sv */
`default_nettype none

module cfg_regs
   import yolo_write_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  clear,
   input  logic                  valid,
   input  logic                  wstrb,
   input  logic [cfg_addr_w-1:0] addr,
   input  logic [data_w-1:0]     wdata,
   output gen_cfg_t              vw_gen,
   output gen_cfg_t              vr_gen,
   output xy_cfg_t               xy,
   output ext_addr_t             vw_base,
   output ext_addr_t             vr_base,
   output logic [off_w-1:0]      vw_offset,
   output logic [off_w-1:0]      vr_offset,
   output logic [axi_len_w-1:0]  vw_len,
   output logic [axi_len_w-1:0]  vr_len,
   output logic [axi_size_w-1:0] vw_size
);

   logic wr;

   assign wr = valid & wstrb;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         vw_gen    <= '0;
         vr_gen    <= '0;
         xy        <= '0;
         vw_base   <= '0;
         vr_base   <= '0;
         vw_offset <= '0;
         vr_offset <= '0;
         vw_len    <= '0;
         vr_len    <= '0;
         vw_size   <= '0;
      end else if (clear) begin
         vw_gen    <= '0;
         vr_gen    <= '0;
         xy        <= '0;
         vw_base   <= '0;
         vr_base   <= '0;
         vw_offset <= '0;
         vr_offset <= '0;
         vw_len    <= '0;
         vr_len    <= '0;
         vw_size   <= '0;
      end else if (wr) begin
         case (addr)
            reg_vw_start:    vw_gen.start <= wdata[mem_addr_w-1:0];
            reg_vw_iter:     vw_gen.iter  <= wdata[mem_addr_w-1:0];
            reg_vw_per:      vw_gen.per   <= wdata[period_w-1:0];
            reg_vw_duty:     vw_gen.duty  <= wdata[period_w-1:0];
            reg_vw_delay:    vw_gen.delay <= wdata[period_w-1:0];
            reg_vw_shift:    vw_gen.shift <= wdata[mem_addr_w-1:0];
            reg_vw_incr:     vw_gen.incr  <= wdata[mem_addr_w-1:0];
            reg_vw_ext_addr: vw_base      <= wdata[io_addr_w-1:0];
            reg_vw_offset:   vw_offset    <= wdata[off_w-1:0];
            reg_vw_len:      vw_len       <= wdata[axi_len_w-1:0];
            reg_vw_size:     vw_size      <= wdata[axi_size_w-1:0];
            reg_vr_start:    vr_gen.start <= wdata[mem_addr_w-1:0];
            reg_vr_iter:     vr_gen.iter  <= wdata[mem_addr_w-1:0];
            // read side runs at full duty, so duty tracks the period
            reg_vr_per: begin
               vr_gen.per  <= wdata[period_w-1:0];
               vr_gen.duty <= wdata[period_w-1:0];
            end
            reg_vr_shift:    vr_gen.shift <= wdata[mem_addr_w-1:0];
            reg_vr_incr:     vr_gen.incr  <= wdata[mem_addr_w-1:0];
            reg_vr_ext_addr: vr_base      <= wdata[io_addr_w-1:0];
            reg_vr_offset:   vr_offset    <= wdata[off_w-1:0];
            reg_vr_len:      vr_len       <= wdata[axi_len_w-1:0];
            reg_xy_iter:     xy.iter      <= wdata[mem_addr_w-1:0];
            reg_xy_per:      xy.per       <= wdata[period_w-1:0];
            reg_xy_bypass:   xy.bypass    <= wdata[0];
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

/* ext_addr_calc.sv */
`default_nettype none

module ext_addr_calc
   import yolo_write_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst,
   input  ext_addr_t                base,
   input  logic [off_w-1:0]         offset,
   output ext_addr_t [n_stages-1:0] stage_addr
);

   // stage i starts i offsets above the base
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         stage_addr <= '0;
      end else begin
         for (int i = 0; i < n_stages; i++) begin
            stage_addr[i] <= base + ext_addr_t'(i) * ext_addr_t'(offset);
         end
      end
   end

endmodule

`default_nettype wire

/* load_ctrl.sv */
`default_nettype none

module load_ctrl
   import yolo_write_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      start_pulse,
   input  logic      bypass,
   input  mem_addr_t xy_addr,
   output logic      ld_acc,
   output logic      ld_mp,
   output logic      ld_res
);

   logic       acc_d1;
   logic       acc_d2;
   logic [1:0] mp_cnt;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         acc_d1 <= 1'b0;
         acc_d2 <= 1'b0;
         mp_cnt <= 2'd0;
      end else if (start_pulse) begin
         acc_d1 <= 1'b0;
         acc_d2 <= 1'b0;
         mp_cnt <= bypass ? 2'd0 : 2'd3;
      end else begin
         acc_d1 <= (xy_addr == '0);
         acc_d2 <= acc_d1;
         // pooling window only advances when results are real
         if (ld_res && !bypass) begin
            mp_cnt <= mp_cnt + 2'd1;
         end
      end
   end

   assign ld_acc = acc_d2;
   assign ld_res = acc_d2 | bypass;
   assign ld_mp  = |mp_cnt;

endmodule

`default_nettype wire

/* project.f */
yolo_write_pkg.sv
cfg_regs.sv
ext_addr_calc.sv
run_delay_line.sv
addr_gen.sv
load_ctrl.sv
yolo_write_top.sv
tb_yolo_write_checks.sv
tb_yolo_write.sv

/* run_delay_line.sv */
`default_nettype none

module run_delay_line #(
   parameter type payload_t = logic,
   parameter int  depth     = 1
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     run,
   input  payload_t d,
   output payload_t q
);

   payload_t stage_q [depth];

   // one layer configuration per slot that advances once per run
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < depth; i++) begin
            stage_q[i] <= '0;
         end
      end else if (run) begin
         stage_q[0] <= d;
         for (int i = 1; i < depth; i++) begin
            stage_q[i] <= stage_q[i-1];
         end
      end
   end

   assign q = stage_q[depth-1];

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tb_yolo_write -o sim_tb_yolo_write
./obj_dir/sim_tb_yolo_write | tee sim.log

if grep -q "TB PASSED" sim.log; then
   exit 0
else
   exit 1
fi

/* tb_yolo_write.sv */
`default_nettype none

module tb_yolo_write
   import yolo_write_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   logic                     clk;
   logic                     rst;
   logic                     clear;
   logic                     run;
   logic                     valid;
   logic                     wstrb;
   logic [cfg_addr_w-1:0]    addr;
   logic [data_w-1:0]        wdata;
   mem_addr_t                vread_addr;
   mem_addr_t                vwrite_addr;
   logic                     vread_en;
   logic                     vwrite_en;
   logic                     ld_acc;
   logic                     ld_mp;
   logic                     ld_res;
   ext_addr_t [n_stages-1:0] vread_ext_addr;
   ext_addr_t [n_stages-1:0] vwrite_ext_addr;
   logic [2*axi_len_w-1:0]   dma_len;
   logic [axi_size_w-1:0]    dma_size;
   logic                     done;
   logic                     window;
   int                       cycle_cnt = 0;
   int                       cycle_limit = 0;
   int                       tb_errors = 0;

   yolo_write_top yolo_write_top_inst (
      .clk (clk), .rst (rst), .clear (clear), .run (run), .valid (valid),
      .addr (addr), .wdata (wdata), .wstrb (wstrb),
      .vread_addr (vread_addr), .vread_en (vread_en),
      .vwrite_addr (vwrite_addr), .vwrite_en (vwrite_en),
      .ld_acc (ld_acc), .ld_mp (ld_mp), .ld_res (ld_res),
      .vread_ext_addr (vread_ext_addr), .vwrite_ext_addr (vwrite_ext_addr),
      .dma_len (dma_len), .dma_size (dma_size), .done (done)
   );

   tb_yolo_write_checks checks_inst (
      .clk (clk), .window (window),
      .vread_addr (vread_addr), .vread_en (vread_en),
      .vwrite_addr (vwrite_addr), .vwrite_en (vwrite_en),
      .ld_acc (ld_acc), .ld_mp (ld_mp), .ld_res (ld_res), .done (done)
   );

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
         $display("timeout: the DUT did not finish within %0d cycles", cycle_limit);
         $display("TB FAILED");
         $finish;
      end
   end

   task automatic skip_line(int fd);
      int c;
      c = $fgetc(fd);
      while (c != 10 && c != -1) c = $fgetc(fd);
   endtask

   // budget from stream lengths, idle time, writes and runs
   task automatic compute_cycle_limit();
      int          fd;
      int          rc;
      int          budget;
      logic [63:0] tok;
      logic [31:0] n;
      budget = 0;
      fd = $fopen("yolo_write_trace.txt", "r");
      if (fd != 0) begin
         rc = $fscanf(fd, "%s", tok);
         while (rc == 1) begin
            if (tok == "#") skip_line(fd);
            else if (tok == "A" || tok == "W") budget += 1;
            else if (tok == "R") budget += 10;
            else if (tok == "I") begin
               rc = $fscanf(fd, "%h", n);
               budget += int'(n);
            end
            rc = $fscanf(fd, "%s", tok);
         end
         $fclose(fd);
      end
      cycle_limit = budget * 2 + 200;
   endtask

   task automatic idle_cycles(int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic write_reg(logic [cfg_addr_w-1:0] a, logic [data_w-1:0] d);
      valid = 1'b1;
      wstrb = 1'b1;
      addr  = a;
      wdata = d;
      idle_cycles(1);
      valid = 1'b0;
      wstrb = 1'b0;
   endtask

   task automatic pulse_clear();
      clear = 1'b1;
      idle_cycles(1);
      clear = 1'b0;
   endtask

   // generators load one edge after run is seen
   task automatic pulse_run();
      run = 1'b1;
      idle_cycles(1);
      run = 1'b0;
      idle_cycles(1);
      window = 1'b1;
   endtask

   task automatic wait_for_done();
      while (done !== 1'b1) idle_cycles(1);
   endtask

   task automatic reset_state_ok();
      checks_inst.bit_equal("done", done, 1'b1);
      checks_inst.bit_equal("vread_en", vread_en, 1'b0);
      checks_inst.bit_equal("vwrite_en", vwrite_en, 1'b0);
      checks_inst.bit_equal("ld_acc", ld_acc, 1'b0);
      checks_inst.bit_equal("ld_mp", ld_mp, 1'b0);
      checks_inst.bit_equal("ld_res", ld_res, 1'b0);
   endtask

   initial begin
      int          fd;
      int          rc;
      int          total;
      logic [63:0] tok;
      logic [31:0] a0;
      logic [31:0] a1;
      logic [31:0] a2;
      logic [31:0] a3;
      clk    = 1'b0;
      rst    = 1'b1;
      clear  = 1'b0;
      run    = 1'b0;
      valid  = 1'b0;
      wstrb  = 1'b0;
      addr   = '0;
      wdata  = '0;
      window = 1'b0;
      compute_cycle_limit();
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;
      fd = $fopen("yolo_write_trace.txt", "r");
      if (fd == 0) begin
         $display("cannot open the trace file yolo_write_trace.txt");
         tb_errors++;
         rc = 0;
      end else begin
         rc = $fscanf(fd, "%s", tok);
      end
      while (rc == 1) begin
         case (tok)
            "#": skip_line(fd);
            "S": reset_state_ok();
            "W": begin
               rc = $fscanf(fd, "%h %h", a0, a1);
               write_reg(a0[cfg_addr_w-1:0], a1);
            end
            "C": pulse_clear();
            "R": pulse_run();
            "D": wait_for_done();
            "I": begin
               rc = $fscanf(fd, "%h", a0);
               idle_cycles(int'(a0));
            end
            "A": begin
               rc = $fscanf(fd, "%h %h", a0, a1);
               checks_inst.expect_addr(a0[0], a1[mem_addr_w-1:0]);
            end
            "X": begin
               rc = $fscanf(fd, "%h %h %h", a0, a1, a2);
               if (a0[0])
                  checks_inst.ext_addr_equal($sformatf("vwrite_ext_addr[%0d]", a1[1:0]),
                                             vwrite_ext_addr[a1[1:0]], a2);
               else
                  checks_inst.ext_addr_equal($sformatf("vread_ext_addr[%0d]", a1[1:0]),
                                             vread_ext_addr[a1[1:0]], a2);
            end
            "L": begin
               rc = $fscanf(fd, "%h %h", a0, a1);
               checks_inst.len_equal("dma_len", dma_len, a0[2*axi_len_w-1:0]);
               checks_inst.size_equal("dma_size", dma_size, a1[axi_size_w-1:0]);
            end
            "P": begin
               rc = $fscanf(fd, "%h %h %h %h", a0, a1, a2, a3);
               checks_inst.load_flags_match(int'(a0), a1[0], a2[0], a3[0]);
            end
            "K": begin
               window = 1'b0;
               checks_inst.compare_streams();
            end
            default: begin
               $display("unknown record %s in the trace file", tok);
               tb_errors++;
            end
         endcase
         rc = $fscanf(fd, "%s", tok);
      end
      if (fd != 0) $fclose(fd);
      total = checks_inst.value_errors + checks_inst.other_errors + tb_errors;
      $display("errors: %0d value mismatches, %0d other failures",
               checks_inst.value_errors, checks_inst.other_errors + tb_errors);
      if (total == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb_yolo_write_checks.sv */
`default_nettype none

module tb_yolo_write_checks
   import yolo_write_pkg::*;
(
   input logic      clk,
   input logic      window,
   input mem_addr_t vread_addr,
   input logic      vread_en,
   input mem_addr_t vwrite_addr,
   input logic      vwrite_en,
   input logic      ld_acc,
   input logic      ld_mp,
   input logic      ld_res,
   input logic      done
);
   timeunit 1ns;
   timeprecision 100ps;

   int        value_errors = 0;
   int        other_errors = 0;
   mem_addr_t exp_rd[$];
   mem_addr_t exp_wr[$];
   mem_addr_t got_rd[$];
   mem_addr_t got_wr[$];
   int        acc_cnt = 0;
   logic      res_low = 1'b0;
   logic      mp_seen = 1'b0;
   logic      done_low = 1'b0;

   // sampled mid-cycle away from the drive edge
   always @(negedge clk) begin
      if (window) begin
         if (vread_en) got_rd.push_back(vread_addr);
         if (vwrite_en) got_wr.push_back(vwrite_addr);
         if (ld_acc) acc_cnt++;
         if (!ld_res) res_low = 1'b1;
         if (ld_mp) mp_seen = 1'b1;
         if (!done) done_low = 1'b1;
      end
   end

   task automatic mem_addr_equal(string name, mem_addr_t got, mem_addr_t exp);
      if (got !== exp) begin
         $display("error %s got %h expected %h", name, got, exp);
         value_errors++;
      end
   endtask

   task automatic ext_addr_equal(string name, ext_addr_t got, ext_addr_t exp);
      if (got !== exp) begin
         $display("error %s got %h expected %h", name, got, exp);
         value_errors++;
      end
   endtask

   task automatic bit_equal(string name, logic got, logic exp);
      if (got !== exp) begin
         $display("error %s got %h expected %h", name, got, exp);
         value_errors++;
      end
   endtask

   task automatic len_equal(string name, logic [2*axi_len_w-1:0] got,
                            logic [2*axi_len_w-1:0] exp);
      if (got !== exp) begin
         $display("error %s got %h expected %h", name, got, exp);
         value_errors++;
      end
   endtask

   task automatic size_equal(string name, logic [axi_size_w-1:0] got,
                             logic [axi_size_w-1:0] exp);
      if (got !== exp) begin
         $display("error %s got %h expected %h", name, got, exp);
         value_errors++;
      end
   endtask

   task automatic count_equal(string name, int got, int exp);
      if (got != exp) begin
         $display("error %s got %h expected %h", name, got, exp);
         value_errors++;
      end
   endtask

   task automatic expect_addr(logic wr_side, mem_addr_t value);
      if (wr_side) exp_wr.push_back(value);
      else exp_rd.push_back(value);
   endtask

   task automatic load_flags_match(int acc, logic res_all, logic mp, logic dl);
      count_equal("ld_acc pulses", acc_cnt, acc);
      bit_equal("ld_res always high", ~res_low, res_all);
      bit_equal("ld_mp seen", mp_seen, mp);
      bit_equal("done went low", done_low, dl);
   endtask

   task automatic compare_streams();
      if (got_rd.size() != exp_rd.size()) begin
         $display("read stream gave %0d addresses where %0d were expected",
                  got_rd.size(), exp_rd.size());
         other_errors++;
      end else begin
         for (int i = 0; i < got_rd.size(); i++)
            mem_addr_equal($sformatf("vread_addr[%0d]", i), got_rd[i], exp_rd[i]);
      end
      if (got_wr.size() != exp_wr.size()) begin
         $display("write stream gave %0d addresses where %0d were expected",
                  got_wr.size(), exp_wr.size());
         other_errors++;
      end else begin
         for (int i = 0; i < got_wr.size(); i++)
            mem_addr_equal($sformatf("vwrite_addr[%0d]", i), got_wr[i], exp_wr[i]);
      end
      got_rd.delete();
      got_wr.delete();
      exp_rd.delete();
      exp_wr.delete();
      acc_cnt  = 0;
      res_low  = 1'b0;
      mp_seen  = 1'b0;
      done_low = 1'b0;
   endtask

endmodule

`default_nettype wire

/* yolo_write_pkg.sv */
`default_nettype none

package yolo_write_pkg;

   localparam int n_stages   = 4;
   localparam int io_addr_w  = 32;
   localparam int mem_addr_w = 10;
   localparam int period_w   = 10;
   localparam int axi_len_w  = 8;
   localparam int axi_size_w = 3;
   localparam int cfg_addr_w = 6;
   localparam int data_w     = 32;
   // stage offsets only need half the address width
   localparam int off_w      = io_addr_w / 2;

   // cpu register map of one word per register
   localparam logic [cfg_addr_w-1:0] reg_vw_start    = 6'd0;
   localparam logic [cfg_addr_w-1:0] reg_vw_iter     = 6'd1;
   localparam logic [cfg_addr_w-1:0] reg_vw_per      = 6'd2;
   localparam logic [cfg_addr_w-1:0] reg_vw_duty     = 6'd3;
   localparam logic [cfg_addr_w-1:0] reg_vw_delay    = 6'd4;
   localparam logic [cfg_addr_w-1:0] reg_vw_shift    = 6'd5;
   localparam logic [cfg_addr_w-1:0] reg_vw_incr     = 6'd6;
   localparam logic [cfg_addr_w-1:0] reg_vw_ext_addr = 6'd7;
   localparam logic [cfg_addr_w-1:0] reg_vw_offset   = 6'd8;
   localparam logic [cfg_addr_w-1:0] reg_vw_len      = 6'd9;
   localparam logic [cfg_addr_w-1:0] reg_vw_size     = 6'd10;
   localparam logic [cfg_addr_w-1:0] reg_vr_start    = 6'd11;
   localparam logic [cfg_addr_w-1:0] reg_vr_iter     = 6'd12;
   localparam logic [cfg_addr_w-1:0] reg_vr_per      = 6'd13;
   localparam logic [cfg_addr_w-1:0] reg_vr_shift    = 6'd14;
   localparam logic [cfg_addr_w-1:0] reg_vr_incr     = 6'd15;
   localparam logic [cfg_addr_w-1:0] reg_vr_ext_addr = 6'd16;
   localparam logic [cfg_addr_w-1:0] reg_vr_offset   = 6'd17;
   localparam logic [cfg_addr_w-1:0] reg_vr_len      = 6'd18;
   localparam logic [cfg_addr_w-1:0] reg_xy_iter     = 6'd19;
   localparam logic [cfg_addr_w-1:0] reg_xy_per      = 6'd20;
   localparam logic [cfg_addr_w-1:0] reg_xy_bypass   = 6'd21;

   // xyolo index trails the read stream by the read latency
   localparam logic [period_w-1:0] vread_lat = 10'd2;

   localparam int vw_shadow_depth = 3;
   localparam int xy_shadow_depth = 2;
   localparam int vr_shadow_depth = 1;

   typedef logic [mem_addr_w-1:0] mem_addr_t;
   typedef logic [io_addr_w-1:0]  ext_addr_t;

   typedef struct packed {
      mem_addr_t           start;
      mem_addr_t           iter;
      logic [period_w-1:0] per;
      logic [period_w-1:0] duty;
      logic [period_w-1:0] delay;
      mem_addr_t           shift;
      mem_addr_t           incr;
   } gen_cfg_t;

   typedef struct packed {
      logic [axi_len_w-1:0]      len;
      logic [axi_size_w-1:0]     size;
      ext_addr_t [n_stages-1:0] addr;
   } ext_cfg_t;

   typedef struct packed {
      mem_addr_t           iter;
      logic [period_w-1:0] per;
      logic                bypass;
   } xy_cfg_t;

endpackage

`default_nettype wire

/* yolo_write_top.sv */
`default_nettype none

module yolo_write_top
   import yolo_write_pkg::*;
(
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       clear,
   input  logic                       run,
   input  logic                       valid,
   input  logic [cfg_addr_w-1:0]      addr,
   input  logic [data_w-1:0]          wdata,
   input  logic                       wstrb,
   output mem_addr_t                  vread_addr,
   output logic                       vread_en,
   output mem_addr_t                  vwrite_addr,
   output logic                       vwrite_en,
   output logic                       ld_acc,
   output logic                       ld_mp,
   output logic                       ld_res,
   output ext_addr_t [n_stages-1:0]   vread_ext_addr,
   output ext_addr_t [n_stages-1:0]   vwrite_ext_addr,
   output logic [2*axi_len_w-1:0]     dma_len,
   output logic [axi_size_w-1:0]      dma_size,
   output logic                       done
);

   gen_cfg_t                 vw_gen_raw;
   gen_cfg_t                 vr_gen_raw;
   xy_cfg_t                  xy_raw;
   ext_addr_t                vw_base;
   ext_addr_t                vr_base;
   logic [off_w-1:0]         vw_offset;
   logic [off_w-1:0]         vr_offset;
   logic [axi_len_w-1:0]     vw_len;
   logic [axi_len_w-1:0]     vr_len;
   logic [axi_size_w-1:0]    vw_size;
   ext_addr_t [n_stages-1:0] vw_stage_addr;
   ext_addr_t [n_stages-1:0] vr_stage_addr;
   ext_cfg_t                 vw_ext_raw;
   ext_cfg_t                 vr_ext_raw;
   gen_cfg_t                 vw_gen_sh;
   gen_cfg_t                 vr_gen_sh;
   xy_cfg_t                  xy_sh;
   ext_cfg_t                 vw_ext_sh;
   ext_cfg_t                 vr_ext_sh;
   gen_cfg_t                 xy_gen;
   logic                     run_reg;
   logic                     vread_done;
   logic                     vwrite_done;
   mem_addr_t                xy_addr;
   logic                     xy_en;
   mem_addr_t                xy_index;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         run_reg <= 1'b0;
      end else begin
         run_reg <= run;
      end
   end

   cfg_regs cfg_regs_inst (
      .clk       (clk),
      .rst       (rst),
      .clear     (clear),
      .valid     (valid),
      .wstrb     (wstrb),
      .addr      (addr),
      .wdata     (wdata),
      .vw_gen    (vw_gen_raw),
      .vr_gen    (vr_gen_raw),
      .xy        (xy_raw),
      .vw_base   (vw_base),
      .vr_base   (vr_base),
      .vw_offset (vw_offset),
      .vr_offset (vr_offset),
      .vw_len    (vw_len),
      .vr_len    (vr_len),
      .vw_size   (vw_size)
   );

   ext_addr_calc vw_ext_calc (
      .clk        (clk),
      .rst        (rst),
      .base       (vw_base),
      .offset     (vw_offset),
      .stage_addr (vw_stage_addr)
   );

   ext_addr_calc vr_ext_calc (
      .clk        (clk),
      .rst        (rst),
      .base       (vr_base),
      .offset     (vr_offset),
      .stage_addr (vr_stage_addr)
   );

   // read side has no size register of its own
   assign vw_ext_raw = '{len: vw_len, size: vw_size, addr: vw_stage_addr};
   assign vr_ext_raw = '{len: vr_len, size: '0, addr: vr_stage_addr};

   run_delay_line #(.payload_t(gen_cfg_t), .depth(vw_shadow_depth)) vw_gen_line (
      .clk (clk), .rst (rst), .run (run), .d (vw_gen_raw), .q (vw_gen_sh)
   );

   run_delay_line #(.payload_t(ext_cfg_t), .depth(vw_shadow_depth)) vw_ext_line (
      .clk (clk), .rst (rst), .run (run), .d (vw_ext_raw), .q (vw_ext_sh)
   );

   run_delay_line #(.payload_t(xy_cfg_t), .depth(xy_shadow_depth)) xy_line (
      .clk (clk), .rst (rst), .run (run), .d (xy_raw), .q (xy_sh)
   );

   run_delay_line #(.payload_t(gen_cfg_t), .depth(vr_shadow_depth)) vr_gen_line (
      .clk (clk), .rst (rst), .run (run), .d (vr_gen_raw), .q (vr_gen_sh)
   );

   run_delay_line #(.payload_t(ext_cfg_t), .depth(vr_shadow_depth)) vr_ext_line (
      .clk (clk), .rst (rst), .run (run), .d (vr_ext_raw), .q (vr_ext_sh)
   );

   // xyolo index wraps back by one period after each period
   assign xy_gen = '{
      start: '0,
      iter:  xy_sh.iter,
      per:   xy_sh.per,
      duty:  xy_sh.per,
      delay: vread_lat,
      shift: mem_addr_t'(0) - mem_addr_t'(xy_sh.per),
      incr:  mem_addr_t'(1)
   };

   addr_gen vread_gen (
      .clk (clk), .rst (rst), .start_pulse (run_reg), .cfg (vr_gen_sh),
      .addr (vread_addr), .en (vread_en), .done (vread_done)
   );

   addr_gen vwrite_gen (
      .clk (clk), .rst (rst), .start_pulse (run_reg), .cfg (vw_gen_sh),
      .addr (vwrite_addr), .en (vwrite_en), .done (vwrite_done)
   );

   addr_gen xy_gen_inst (
      .clk (clk), .rst (rst), .start_pulse (run_reg), .cfg (xy_gen),
      .addr (xy_addr), .en (xy_en), .done ()
   );

   // idle index must not look like the first beat of a period
   assign xy_index = xy_en ? xy_addr : '1;

   load_ctrl load_ctrl_inst (
      .clk         (clk),
      .rst         (rst),
      .start_pulse (run_reg),
      .bypass      (xy_sh.bypass),
      .xy_addr     (xy_index),
      .ld_acc      (ld_acc),
      .ld_mp       (ld_mp),
      .ld_res      (ld_res)
   );

   assign vread_ext_addr  = vr_ext_sh.addr;
   assign vwrite_ext_addr = vw_ext_sh.addr;
   assign dma_len         = {vw_ext_sh.len, vr_ext_sh.len};
   assign dma_size        = vw_ext_sh.size;
   assign done            = vread_done & vwrite_done;

endmodule

`default_nettype wire

/* yolo_write_trace.txt */
# records: S reset state, W addr data, C clear, R run, D wait done, I idle cycles, K compare
# A side(0 read 1 write) addr, X side stage addr, L dma_len dma_size, P acc res mp done_low
S
W 0b 5 W 0c 2 W 0d 3 W 0e 0a W 0f 2 W 10 1000 W 11 40 W 12 0f
W 00 64 W 01 2 W 02 4 W 03 2 W 04 3 W 05 1 W 06 4
W 07 80000000 W 08 100 W 09 1f W 0a 2
W 13 2 W 14 3 W 15 0
I 2
# run 1: read layer only, write and xyolo still empty
R D I 8
A 0 5 A 0 7 A 0 9 A 0 13 A 0 15 A 0 17
P 0 0 1 1 L 000f 0 X 0 1 1040 X 0 3 10c0 X 1 0 0 K
# run 2: xyolo layer arrives
R D I 8
A 0 5 A 0 7 A 0 9 A 0 13 A 0 15 A 0 17
P 2 0 1 1 L 000f 0 X 1 3 0 K
W 15 1 I 2
# run 3: write layer arrives
R D I 8
A 0 5 A 0 7 A 0 9 A 0 13 A 0 15 A 0 17 A 1 64 A 1 68 A 1 71 A 1 75
P 2 0 1 1 L 1f0f 2 X 1 0 80000000 X 1 1 80000100 X 1 2 80000200 X 1 3 80000300 K
# run 4: bypass layer on xyolo
R D I 8
A 0 5 A 0 7 A 0 9 A 0 13 A 0 15 A 0 17 A 1 64 A 1 68 A 1 71 A 1 75
P 2 1 0 1 K
C I 2
# runs 5 and 6 drain the write layers still in flight
R D I 8 A 1 64 A 1 68 A 1 71 A 1 75 X 0 2 0 K
R D I 8 A 1 64 A 1 68 A 1 71 A 1 75 K
R D I 8 P 0 0 1 0 L 0000 0 X 1 0 0 K
